/* filelist.f */
+incdir+source
source/csr_pkg.sv
source/csr_event_counter.sv
source/csr_commit_ctrl.sv
source/csr_trap_regs.sv
source/csr_read_mux.sv
source/csr_unit.sv
tests/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_unit_tb -f filelist.f -o csr_unit_sim

output="$(./obj_dir/csr_unit_sim 2>&1 || true)"
printf '%s\n' "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* source/csr_commit_ctrl.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_commit_ctrl (
    input  logic                         stall,
    input  logic                         flush,
    input  logic                         retire_flush,
    input  logic                         exception,
    input  logic                         mret,
    input  logic                         write,
    input  logic                         instr_retired,
    input  logic                         src_reg,
    input  csr_pkg::csr_write_op_e       write_op,
    input  logic [`CSR_XLEN-1:0]         rs1_value,
    input  logic [`CSR_XLEN-1:0]         imm_value,
    input  logic [`CSR_XLEN-1:0]         old_value,
    output logic                         write_commit,
    output logic                         take_exception,
    output logic                         take_mret,
    output logic                         trap,
    output logic [`CSR_XLEN-1:0]         new_value,
    output logic [`CSR_NUM_COUNTERS-1:0] count_inc
);
    import csr_pkg::*;

    logic                 commit;
    logic [`CSR_XLEN-1:0] operand;

    assign commit  = !stall && !flush;
    assign operand = src_reg ? rs1_value : imm_value;

    always_comb begin
        case (write_op)
            CSR_OP_RW: new_value = operand;
            CSR_OP_RS: new_value = old_value | operand;
            CSR_OP_RC: new_value = old_value & ~operand;
            default:   new_value = old_value; // Leave the register as it is
        endcase
    end

    assign write_commit   = commit && write;
    assign take_exception = commit && exception;
    assign take_mret      = commit && mret && !exception; // Exception wins
    assign trap           = take_exception || take_mret;

    always_comb begin
        count_inc              = '0;
        count_inc[CNT_CYCLE]   = 1'b1;
        count_inc[CNT_INSTRET] = instr_retired && !retire_flush;
    end

    // A committed write must carry one of the three defined operations
    always_comb begin
        if (write_commit) begin
            a_write_op: assert (write_op inside {CSR_OP_RW, CSR_OP_RS, CSR_OP_RC})
                else $error("illegal CSR write op %0b", write_op);
        end
    end

endmodule

/* source/csr_event_counter.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_event_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inc,
    output logic [`CSR_COUNT_W-1:0] count
);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (inc) begin
            count <= count + 1'b1;
        end
    end

    // 64 bits never wrap in practice, so the count only grows between resets
    a_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) && !$isunknown($past(count)) |-> count >= $past(count)
    ) else $error("event counter went backwards");

endmodule

/* source/csr_pkg.sv */
`include "csr_settings.svh"

package csr_pkg;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MINSTRETH = 12'hB82,
        CSR_CYCLE     = 12'hC00,
        CSR_TIME      = 12'hC01,
        CSR_INSTRET   = 12'hC02,
        CSR_CYCLEH    = 12'hC80,
        CSR_TIMEH     = 12'hC81,
        CSR_INSTRETH  = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_OP_RW = 2'b00, // Write
        CSR_OP_RS = 2'b01, // Set bits
        CSR_OP_RC = 2'b10  // Clear bits
    } csr_write_op_e;

    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_INSTR_FAULT      = 4'd1,
        EXC_INSTR_ILLEGAL    = 4'd2,
        EXC_BREAKPOINT       = 4'd3,
        EXC_LOAD_MISALIGNED  = 4'd4,
        EXC_LOAD_FAULT       = 4'd5,
        EXC_STORE_MISALIGNED = 4'd6,
        EXC_STORE_FAULT      = 4'd7,
        EXC_MACHINE_ECALL    = 4'd11
    } exc_cause_e;

    typedef enum logic [$clog2(`CSR_NUM_COUNTERS)-1:0] {
        CNT_CYCLE   = 0,
        CNT_INSTRET = 1
    } csr_counter_e;

endpackage

/* source/csr_read_mux.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_e      csr_addr,
    input  logic                    mstatus_mie,
    input  logic                    mstatus_mpie,
    input  logic [2:0]              mie_bits,
    input  logic [29:0]             mtvec_base,
    input  logic                    mtvec_mode,
    input  logic [`CSR_XLEN-1:0]    mscratch,
    input  logic [`CSR_XLEN-1:0]    mtval,
    input  logic [29:0]             mepc,
    input  logic                    mcause_interrupt,
    input  logic [3:0]              mcause_code,
    input  logic [`CSR_COUNT_W-1:0] counts [`CSR_NUM_COUNTERS],
    output logic [`CSR_XLEN-1:0]    read_value
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] mstatus_img;
    logic [`CSR_XLEN-1:0] mie_img;
    logic [`CSR_XLEN-1:0] cycle_lo;
    logic [`CSR_XLEN-1:0] cycle_hi;
    logic [`CSR_XLEN-1:0] instret_lo;
    logic [`CSR_XLEN-1:0] instret_hi;

    // MPP is hardwired to machine mode
    assign mstatus_img = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mie_img     = {20'b0, mie_bits[2], 3'b0, mie_bits[1], 3'b0, mie_bits[0], 3'b0};

    assign cycle_lo   = counts[CNT_CYCLE][`CSR_XLEN-1:0];
    assign cycle_hi   = counts[CNT_CYCLE][`CSR_COUNT_W-1:`CSR_XLEN];
    assign instret_lo = counts[CNT_INSTRET][`CSR_XLEN-1:0];
    assign instret_hi = counts[CNT_INSTRET][`CSR_COUNT_W-1:`CSR_XLEN];

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS:   read_value = mstatus_img;
            CSR_MISA:      read_value = `CSR_MISA_VALUE;
            CSR_MIE:       read_value = mie_img;
            CSR_MTVEC:     read_value = {mtvec_base, 1'b0, mtvec_mode};
            CSR_MSCRATCH:  read_value = mscratch;
            CSR_MEPC:      read_value = {mepc, 2'b00};
            CSR_MCAUSE:    read_value = {mcause_interrupt, 27'b0, mcause_code};
            CSR_MTVAL:     read_value = mtval;
            CSR_MCYCLE,
            CSR_CYCLE,
            CSR_TIME:      read_value = cycle_lo; // time aliases cycle
            CSR_MCYCLEH,
            CSR_CYCLEH,
            CSR_TIMEH:     read_value = cycle_hi;
            CSR_MINSTRET,
            CSR_INSTRET:   read_value = instret_lo;
            CSR_MINSTRETH,
            CSR_INSTRETH:  read_value = instret_hi;
            default:       read_value = '0;
        endcase
    end

endmodule

/* source/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Datapath widths
`define CSR_XLEN    32
`define CSR_ADDR_W  12
`define CSR_COUNT_W 64

// Event counters, index 0 is cycle and index 1 is instret
`define CSR_NUM_COUNTERS 2

// MXL = 1 (RV32), extension bit 8 (I)
`define CSR_MISA_VALUE 32'h4000_0100

`endif

/* source/csr_trap_regs.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write_commit,
    input  logic                 take_exception,
    input  logic                 take_mret,
    input  csr_pkg::csr_addr_e   csr_addr,
    input  logic [`CSR_XLEN-1:0] new_value,
    input  logic [`CSR_XLEN-1:0] pc,
    input  csr_pkg::exc_cause_e  exception_cause,
    output logic                 mstatus_mie,
    output logic                 mstatus_mpie,
    output logic [2:0]           mie_bits,
    output logic [29:0]          mtvec_base,
    output logic                 mtvec_mode,
    output logic [`CSR_XLEN-1:0] mscratch,
    output logic [`CSR_XLEN-1:0] mtval,
    output logic [29:0]          mepc,
    output logic                 mcause_interrupt,
    output logic [3:0]           mcause_code,
    output logic [`CSR_XLEN-1:0] trap_pc
);
    import csr_pkg::*;

    // Fields without a reset value
    always_ff @(posedge clk) begin
        if (write_commit) begin
            case (csr_addr)
                CSR_MSTATUS:  mstatus_mpie <= new_value[7];
                CSR_MIE:      mie_bits <= {new_value[11], new_value[7], new_value[3]};
                CSR_MTVEC: begin
                    mtvec_base <= new_value[31:2];
                    mtvec_mode <= new_value[0]; // Bit 1 reads back as zero
                end
                CSR_MSCRATCH: mscratch <= new_value;
                CSR_MEPC:     mepc <= new_value[31:2];
                CSR_MTVAL:    mtval <= new_value;
                default: ;
            endcase
        end

        // Trap effects land after the write so they win on overlap
        if (take_exception) begin
            mepc <= pc[31:2];
        end
        if (take_mret) begin
            mstatus_mpie <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie      <= 1'b0;
            mcause_interrupt <= 1'b0;
            mcause_code      <= 4'd0;
        end else begin
            if (write_commit && csr_addr == CSR_MSTATUS) begin
                mstatus_mie <= new_value[3];
            end
            if (write_commit && csr_addr == CSR_MCAUSE) begin
                mcause_interrupt <= new_value[31];
                mcause_code      <= new_value[3:0];
            end

            if (take_exception) begin
                mcause_interrupt <= 1'b0; // Synchronous exception
                mcause_code      <= exception_cause;
            end
            if (take_mret) begin
                mstatus_mie <= mstatus_mpie;
            end
        end
    end

    always_comb begin
        if (take_exception) begin
            trap_pc = {mtvec_base, 2'b00}; // Direct mode only
        end else if (take_mret) begin
            trap_pc = {mepc, 2'b00};
        end else begin
            trap_pc = '0;
        end
    end

    a_one_trap: assert property (
        @(posedge clk) disable iff (reset) !(take_exception && take_mret)
    ) else $error("exception and mret taken together");

endmodule

/* source/csr_unit.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    retire_flush,
    input  logic                    exception,
    input  logic [3:0]              exception_cause,
    input  logic                    write,
    input  logic [1:0]              write_op,
    input  logic                    src_reg,
    input  logic                    mret,
    input  logic                    instr_retired,
    input  logic [`CSR_XLEN-1:0]    pc,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    rs1_value,
    input  logic [`CSR_XLEN-1:0]    imm_value,
    output logic [`CSR_XLEN-1:0]    read_value,
    output logic                    trap,
    output logic [`CSR_XLEN-1:0]    trap_pc,
    output logic [`CSR_COUNT_W-1:0] cycle_count
);
    import csr_pkg::*;

    csr_addr_e                    addr;
    logic                         write_commit;
    logic                         take_exception;
    logic                         take_mret;
    logic [`CSR_XLEN-1:0]         new_value;
    logic [`CSR_NUM_COUNTERS-1:0] count_inc;
    logic [`CSR_COUNT_W-1:0]      counts [`CSR_NUM_COUNTERS];

    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic [2:0]           mie_bits;
    logic [29:0]          mtvec_base;
    logic                 mtvec_mode;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mtval;
    logic [29:0]          mepc;
    logic                 mcause_interrupt;
    logic [3:0]           mcause_code;

    assign addr = csr_addr_e'(csr_addr); // Unlisted codes fall to the mux default

    csr_commit_ctrl u_ctrl (
        .stall, .flush, .retire_flush,
        .exception, .mret, .write, .instr_retired, .src_reg,
        .write_op       (csr_write_op_e'(write_op)),
        .rs1_value, .imm_value,
        .old_value      (read_value),
        .write_commit, .take_exception, .take_mret, .trap,
        .new_value, .count_inc
    );

    for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : g_counter
        csr_event_counter u_counter (
            .clk, .reset,
            .inc   (count_inc[i]),
            .count (counts[i])
        );
    end

    csr_trap_regs u_trap_regs (
        .clk, .reset,
        .write_commit, .take_exception, .take_mret,
        .csr_addr        (addr),
        .new_value, .pc,
        .exception_cause (exc_cause_e'(exception_cause)),
        .mstatus_mie, .mstatus_mpie, .mie_bits, .mtvec_base, .mtvec_mode,
        .mscratch, .mtval, .mepc, .mcause_interrupt, .mcause_code,
        .trap_pc
    );

    csr_read_mux u_read_mux (
        .csr_addr (addr),
        .mstatus_mie, .mstatus_mpie, .mie_bits, .mtvec_base, .mtvec_mode,
        .mscratch, .mtval, .mepc, .mcause_interrupt, .mcause_code,
        .counts,
        .read_value
    );

    assign cycle_count = counts[CNT_CYCLE];

endmodule

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_unit_tb;
    import csr_pkg::*;

    logic                    clk;
    logic                    reset;
    logic                    stall;
    logic                    flush;
    logic                    retire_flush;
    logic                    exception;
    logic [3:0]              exception_cause;
    logic                    write;
    logic [1:0]              write_op;
    logic                    src_reg;
    logic                    mret;
    logic                    instr_retired;
    logic [`CSR_XLEN-1:0]    pc;
    logic [`CSR_ADDR_W-1:0]  csr_addr;
    logic [`CSR_XLEN-1:0]    rs1_value;
    logic [`CSR_XLEN-1:0]    imm_value;
    logic [`CSR_XLEN-1:0]    read_value;
    logic                    trap;
    logic [`CSR_XLEN-1:0]    trap_pc;
    logic [`CSR_COUNT_W-1:0] cycle_count;

    logic [31:0]          rng_state;
    logic [`CSR_XLEN-1:0] model_scratch; // Expected register images
    logic [`CSR_XLEN-1:0] model_mepc;
    logic [`CSR_XLEN-1:0] model_mtvec;

    csr_unit DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [`CSR_XLEN-1:0] expected,
                              input logic [`CSR_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_count(input string name, input logic [`CSR_COUNT_W-1:0] expected,
                               input logic [`CSR_COUNT_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic wait_for_counter_start();
        int waited;
        waited = 0;
        while (cycle_count == '0) begin
            @(negedge clk);
            waited++;
            if (waited > 10) begin
                $display("Timeout: the cycle counter did not start after reset");
                stop_failed();
            end
        end
    endtask

    task automatic read_word(input logic [`CSR_ADDR_W-1:0] addr,
                             output logic [`CSR_XLEN-1:0] value);
        @(negedge clk);
        csr_addr = addr;
        #1;
        value = read_value;
    endtask

    task automatic read_check(input string name, input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [`CSR_XLEN-1:0] expected);
        logic [`CSR_XLEN-1:0] value;
        read_word(addr, value);
        check_word(name, expected, value);
    endtask

    // The unused operand source gets random data so a wrong mux shows up
    task automatic csr_write(input csr_write_op_e op, input csr_addr_e addr,
                             input logic [`CSR_XLEN-1:0] value, input logic from_reg);
        @(negedge clk);
        write     = 1'b1;
        write_op  = op;
        csr_addr  = addr;
        src_reg   = from_reg;
        rs1_value = from_reg ? value : next_random();
        imm_value = from_reg ? next_random() : value;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic pulse_exception(input exc_cause_e cause, input logic [`CSR_XLEN-1:0] at_pc,
                                   input logic taken);
        @(negedge clk);
        exception       = 1'b1;
        exception_cause = cause;
        pc              = at_pc;
        #1;
        check_bit("trap", taken, trap);
        if (taken)
            check_word("trap_pc", model_mtvec & ~32'h3, trap_pc);
        @(negedge clk);
        exception = 1'b0;
    endtask

    task automatic pulse_mret(input logic taken);
        @(negedge clk);
        mret = 1'b1;
        #1;
        check_bit("trap", taken, trap);
        if (taken)
            check_word("trap_pc", model_mepc, trap_pc);
        @(negedge clk);
        mret = 1'b0;
    endtask

    task automatic test_reset();
        check_bit("trap", 1'b0, trap);
        csr_write(CSR_OP_RC, CSR_MSTATUS, 32'h80, 1'b0); // MPIE has no reset value
        read_check("mstatus", CSR_MSTATUS, 32'h1800);
        read_check("mcause", CSR_MCAUSE, 32'h0);
        read_check("misa", CSR_MISA, `CSR_MISA_VALUE);
        read_check("unimplemented csr", 12'h7C0, 32'h0);
    endtask

    task automatic test_scratch_ops();
        logic [`CSR_XLEN-1:0] value;
        logic [31:0]          pick;
        csr_write_op_e        op;
        model_scratch = next_random();
        csr_write(CSR_OP_RW, CSR_MSCRATCH, model_scratch, 1'b1);
        for (int i = 0; i < 15; i++) begin
            value = next_random();
            pick  = next_random();
            case (pick[1:0])
                2'd1: begin
                    op            = CSR_OP_RS;
                    model_scratch = model_scratch | value;
                end
                2'd2: begin
                    op            = CSR_OP_RC;
                    model_scratch = model_scratch & ~value;
                end
                default: begin
                    op            = CSR_OP_RW;
                    model_scratch = value;
                end
            endcase
            csr_write(op, CSR_MSCRATCH, value, i[0]);
            read_check("mscratch", CSR_MSCRATCH, model_scratch);
        end
    endtask

    task automatic test_field_masks();
        logic [`CSR_XLEN-1:0] value;
        csr_write(CSR_OP_RW, CSR_MSTATUS, '1, 1'b1);
        csr_write(CSR_OP_RW, CSR_MIE, '1, 1'b0);
        csr_write(CSR_OP_RW, CSR_MTVEC, '1, 1'b1);
        csr_write(CSR_OP_RW, CSR_MEPC, '1, 1'b0);
        csr_write(CSR_OP_RW, CSR_MCAUSE, '1, 1'b1);
        read_check("mstatus", CSR_MSTATUS, 32'h1888);
        read_check("mie", CSR_MIE, 32'h888);
        read_check("mtvec", CSR_MTVEC, 32'hFFFF_FFFD);
        read_check("mepc", CSR_MEPC, 32'hFFFF_FFFC);
        read_check("mcause", CSR_MCAUSE, 32'h8000_000F);
        value = next_random(); // mtval keeps every bit
        csr_write(CSR_OP_RW, CSR_MTVAL, value, 1'b0);
        read_check("mtval", CSR_MTVAL, value);
    endtask

    task automatic test_trap();
        logic [`CSR_XLEN-1:0] at_pc;
        model_mtvec = next_random() & ~32'h2;
        csr_write(CSR_OP_RW, CSR_MTVEC, model_mtvec, 1'b0);
        read_check("mtvec", CSR_MTVEC, model_mtvec);
        csr_write(CSR_OP_RW, CSR_MSTATUS, 32'h8, 1'b1); // MIE set, MPIE clear
        at_pc = next_random();
        pulse_exception(EXC_LOAD_FAULT, at_pc, 1'b1);
        model_mepc = at_pc & ~32'h3;
        read_check("mepc", CSR_MEPC, model_mepc);
        read_check("mcause", CSR_MCAUSE, 32'h5);
        pulse_mret(1'b1);
        read_check("mstatus", CSR_MSTATUS, 32'h1880);
        pulse_mret(1'b1);
        read_check("mstatus", CSR_MSTATUS, 32'h1888);
        check_bit("trap", 1'b0, trap);
    endtask

    task automatic test_blocked(input logic use_stall);
        @(negedge clk);
        stall = use_stall;
        flush = !use_stall;
        csr_write(CSR_OP_RW, CSR_MSCRATCH, next_random(), 1'b1);
        csr_write(CSR_OP_RC, CSR_MSTATUS, '1, 1'b0);
        pulse_exception(EXC_MACHINE_ECALL, next_random(), 1'b0);
        pulse_mret(1'b0);
        read_check("mscratch", CSR_MSCRATCH, model_scratch);
        read_check("mstatus", CSR_MSTATUS, 32'h1888);
        read_check("mepc", CSR_MEPC, model_mepc);
        read_check("mcause", CSR_MCAUSE, 32'h5);
        @(negedge clk);
        stall = 1'b0;
        flush = 1'b0;
    endtask

    task automatic test_counters();
        logic [`CSR_COUNT_W-1:0] start;
        logic [`CSR_COUNT_W-1:0] cycles;
        logic [`CSR_XLEN-1:0]    retired;
        logic [31:0]             pick;
        int                      edges;
        @(negedge clk);
        #1;
        start = cycle_count;
        edges = 5 + int'(next_random() & 32'hF);
        repeat (edges) @(negedge clk);
        #1;
        cycles = start + 64'(edges);
        check_count("cycle_count", cycles, cycle_count);

        // Each read passes one more rising edge
        cycles = cycles + 64'd1;
        read_check("cycle", CSR_CYCLE, cycles[31:0]);
        cycles = cycles + 64'd1;
        read_check("time", CSR_TIME, cycles[31:0]);
        cycles = cycles + 64'd1;
        read_check("mcycle", CSR_MCYCLE, cycles[31:0]);
        cycles = cycles + 64'd1;
        read_check("cycleh", CSR_CYCLEH, cycles[63:32]);
        cycles = cycles + 64'd1;
        read_check("timeh", CSR_TIMEH, cycles[63:32]);
        cycles = cycles + 64'd1;
        read_check("mcycleh", CSR_MCYCLEH, cycles[63:32]);

        retired = '0; // No instruction retired since reset
        for (int i = 0; i < 16; i++) begin
            pick = next_random();
            @(negedge clk);
            instr_retired = pick[0];
            retire_flush  = pick[1];
            if (pick[0] && !pick[1])
                retired = retired + 32'd1;
        end
        @(negedge clk);
        instr_retired = 1'b0;
        retire_flush  = 1'b0;
        read_check("minstret", CSR_MINSTRET, retired);
        read_check("instret", CSR_INSTRET, retired);
        read_check("minstreth", CSR_MINSTRETH, 32'h0);
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        stall           = 1'b0;
        flush           = 1'b0;
        retire_flush    = 1'b0;
        exception       = 1'b0;
        exception_cause = 4'd0;
        write           = 1'b0;
        write_op        = 2'b00;
        src_reg         = 1'b0;
        mret            = 1'b0;
        instr_retired   = 1'b0;
        pc              = '0;
        csr_addr        = '0;
        rs1_value       = '0;
        imm_value       = '0;
        rng_state       = 32'h517a_188a;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_for_counter_start();

        test_reset();
        test_scratch_ops();
        test_field_masks();
        test_trap();
        test_blocked(1'b1);
        test_blocked(1'b0);
        test_counters();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
